/* hdl/rename_pkg.sv */
// sizes, index types and instruction packets shared by the rename core, taken by scoped name
package rename_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int ARCH_REG_COUNT = 32;
    localparam int PHYS_REG_COUNT = 48;
    localparam int ROB_SIZE       = PHYS_REG_COUNT - ARCH_REG_COUNT; // one spare reg per rob slot
    localparam int IQ_DEPTH       = 8;

    localparam int ARCH_REG_W = $clog2(ARCH_REG_COUNT);
    localparam int PHYS_REG_W = $clog2(PHYS_REG_COUNT);
    localparam int ROB_IDX_W  = $clog2(ROB_SIZE);
    localparam int IQ_PTR_W   = $clog2(IQ_DEPTH);

    ////////////////////////////////////////////////////////////////////////////
    // index and counter types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [ROB_IDX_W:0]    rob_cnt_t;  // 0..ROB_SIZE, one extra bit
    typedef logic [ROB_IDX_W-1:0]  fl_ptr_t;   // free list holds ROB_SIZE regs
    typedef logic [ROB_IDX_W:0]    fl_cnt_t;
    typedef logic [IQ_PTR_W-1:0]   iq_ptr_t;
    typedef logic [IQ_PTR_W:0]     iq_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // packets
    ////////////////////////////////////////////////////////////////////////////

    // instruction as it arrives
    typedef struct packed {
        logic      has_dest;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
    } inst_t;

    // after rename, sent to dispatch and into the rob
    typedef struct packed {
        arch_reg_t dest;
        logic      has_dest;
        phys_reg_t t;       // new mapping of dest
        phys_reg_t t_old;   // mapping it replaces, freed at commit
        phys_reg_t p1;
        phys_reg_t p2;
        rob_idx_t  rob_idx;
    } renamed_t;

    // retired instruction
    typedef struct packed {
        arch_reg_t dest;
        logic      has_dest;
        phys_reg_t t;
        phys_reg_t t_old;
        rob_idx_t  rob_idx;
    } commit_t;

endpackage

/* hdl/inst_queue.sv */
// instruction queue at the input of the rename core, buffers instructions until rename pops them
module inst_queue (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_valid,  // strobe, dropped while full
    input  rename_pkg::inst_t in_inst,
    input  logic             pop,       // from rename stage
    output rename_pkg::inst_t head,
    output logic             nonempty,
    output logic             full
);

    ////////////////////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////////////////////

    rename_pkg::inst_t   entries [rename_pkg::IQ_DEPTH];
    rename_pkg::iq_ptr_t head_ptr;
    rename_pkg::iq_ptr_t tail_ptr;
    rename_pkg::iq_cnt_t count;

    logic do_push;
    logic do_pop;

    assign full     = (count == rename_pkg::iq_cnt_t'(rename_pkg::IQ_DEPTH));
    assign nonempty = (count != '0);
    assign head     = entries[head_ptr]; // head read straight out of the ring

    assign do_push = in_valid && !full;  // no push while full, even with a pop
    assign do_pop  = pop && nonempty;

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= tail_ptr + rename_pkg::iq_ptr_t'(1);
            end
            if (do_pop) begin
                head_ptr <= head_ptr + rename_pkg::iq_ptr_t'(1);
            end
            count <= count + rename_pkg::iq_cnt_t'(do_push) - rename_pkg::iq_cnt_t'(do_pop);
        end
    end

    // payload write
    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[tail_ptr] <= in_inst;
        end
    end

endmodule

/* hdl/map_table.sv */
// speculative map from architectural to physical registers, read and written by the rename stage
module map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::arch_reg_t src1,
    input  rename_pkg::arch_reg_t src2,
    input  rename_pkg::arch_reg_t dest,
    input  logic                  write_en,   // rename of an inst with a dest
    input  rename_pkg::phys_reg_t write_phys, // new mapping from free list
    output rename_pkg::phys_reg_t p1,
    output rename_pkg::phys_reg_t p2,
    output rename_pkg::phys_reg_t t_old
);

    rename_pkg::phys_reg_t map [rename_pkg::ARCH_REG_COUNT];

    ////////////////////////////////////////////////////////////////////////////
    // reads
    ////////////////////////////////////////////////////////////////////////////

    // all three reads see the table before this cycle's write
    assign p1    = map[src1];
    assign p2    = map[src2];
    assign t_old = map[dest]; // previous owner of dest

    ////////////////////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // arch reg i starts in phys reg i
            for (int i = 0; i < rename_pkg::ARCH_REG_COUNT; i++) begin
                map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (write_en) begin
            map[dest] <= write_phys;
        end
    end

endmodule

/* hdl/free_list.sv */
// circular FIFO of free physical registers, popped on rename and refilled at commit
module free_list (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pop,      // take head_reg this cycle
    input  logic                  push,     // return push_reg at tail
    input  rename_pkg::phys_reg_t push_reg,
    output rename_pkg::phys_reg_t head_reg,
    output logic                  empty
);

    ////////////////////////////////////////////////////////////////////////////
    // ring state
    ////////////////////////////////////////////////////////////////////////////

    rename_pkg::phys_reg_t regs [rename_pkg::ROB_SIZE];
    rename_pkg::fl_ptr_t   head_ptr;
    rename_pkg::fl_ptr_t   tail_ptr;
    rename_pkg::fl_cnt_t   count;

    logic do_pop;

    assign empty    = (count == '0);
    assign head_reg = regs[head_ptr];
    assign do_pop   = pop && !empty; // returned reg is not bypassed to head

    // after reset the list is full, so tail sits on head
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= rename_pkg::fl_cnt_t'(rename_pkg::ROB_SIZE);
            for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
                regs[i] <= rename_pkg::phys_reg_t'(rename_pkg::ARCH_REG_COUNT + i); // 32..47
            end
        end else begin
            if (do_pop) begin
                head_ptr <= head_ptr + rename_pkg::fl_ptr_t'(1);
            end
            if (push) begin
                regs[tail_ptr] <= push_reg;   // commit order
                tail_ptr       <= tail_ptr + rename_pkg::fl_ptr_t'(1);
            end
            count <= count + rename_pkg::fl_cnt_t'(push) - rename_pkg::fl_cnt_t'(do_pop);
        end
    end

endmodule

/* hdl/rename_stage.sv */
// rename stage, pops the queue when resources allow and registers the renamed packet for dispatch
module rename_stage (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::inst_t     iq_head,
    input  logic                  iq_nonempty,
    input  logic                  rob_full,
    input  rename_pkg::rob_idx_t  alloc_idx,      // slot the next rename will take
    input  logic                  commit_valid,
    input  rename_pkg::commit_t   committed,
    output logic                  iq_pop,
    output logic                  dispatch_valid,
    output rename_pkg::renamed_t  dispatched
);

    rename_pkg::phys_reg_t fl_head;   // next free phys reg
    logic                  fl_empty;
    rename_pkg::phys_reg_t mt_p1;
    rename_pkg::phys_reg_t mt_p2;
    rename_pkg::phys_reg_t mt_t_old;
    logic                  do_rename;
    logic                  take_reg;  // rename that also needs a dest reg
    logic                  free_reg;  // commit returning t_old
    rename_pkg::renamed_t  next_pkt;

    ////////////////////////////////////////////////////////////////////////////
    // stall logic
    ////////////////////////////////////////////////////////////////////////////

    // no dest means no free list entry needed
    assign do_rename = iq_nonempty && !rob_full && (!iq_head.has_dest || !fl_empty);
    assign take_reg  = do_rename && iq_head.has_dest;
    assign free_reg  = commit_valid && committed.has_dest;
    assign iq_pop    = do_rename;

    map_table map_table_i (
        .clock      (clock),
        .reset      (reset),
        .src1       (iq_head.src1),
        .src2       (iq_head.src2),
        .dest       (iq_head.dest),
        .write_en   (take_reg),
        .write_phys (fl_head),
        .p1         (mt_p1),
        .p2         (mt_p2),
        .t_old      (mt_t_old)
    );

    free_list free_list_i (
        .clock    (clock),
        .reset    (reset),
        .pop      (take_reg),
        .push     (free_reg),
        .push_reg (committed.t_old),
        .head_reg (fl_head),
        .empty    (fl_empty)
    );

    ////////////////////////////////////////////////////////////////////////////
    // renamed packet
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        next_pkt.dest     = iq_head.dest;
        next_pkt.has_dest = iq_head.has_dest;
        next_pkt.t        = iq_head.has_dest ? fl_head : '0;  // zero without dest
        next_pkt.t_old    = iq_head.has_dest ? mt_t_old : '0;
        next_pkt.p1       = mt_p1;
        next_pkt.p2       = mt_p2;
        next_pkt.rob_idx  = alloc_idx;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= do_rename; // one pulse per pop
        end
    end

    always_ff @(posedge clock) begin
        if (do_rename) begin
            dispatched <= next_pkt;
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
// reorder buffer, allocates on dispatch, marks completions and retires the head in program order
module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  rename_pkg::renamed_t  dispatched,
    input  logic                  complete_valid,
    input  rename_pkg::rob_idx_t  complete_idx,
    output logic                  rob_full,
    output rename_pkg::rob_idx_t  alloc_idx,
    output logic                  commit_valid,
    output rename_pkg::commit_t   committed
);

    ////////////////////////////////////////////////////////////////////////////
    // ring state
    ////////////////////////////////////////////////////////////////////////////

    rename_pkg::commit_t  entries [rename_pkg::ROB_SIZE];
    logic                 done [rename_pkg::ROB_SIZE];
    rename_pkg::rob_idx_t head;
    rename_pkg::rob_idx_t tail;
    rename_pkg::rob_cnt_t count;
    rename_pkg::commit_t  new_entry;
    logic                 retire;

    // the dispatch pulse on the bus has not reached the tail yet,
    // so the index and fullness both look one entry ahead
    assign alloc_idx = dispatch_valid ? tail + rename_pkg::rob_idx_t'(1) : tail;
    assign rob_full  = (count + rename_pkg::rob_cnt_t'(dispatch_valid))
                       >= rename_pkg::rob_cnt_t'(rename_pkg::ROB_SIZE);

    assign retire = (count != '0) && done[head]; // oldest entry finished

    always_comb begin
        new_entry.dest     = dispatched.dest;
        new_entry.has_dest = dispatched.has_dest;
        new_entry.t        = dispatched.t;
        new_entry.t_old    = dispatched.t_old;
        new_entry.rob_idx  = dispatched.rob_idx;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pointers, count and done bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rename_pkg::ROB_SIZE; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (retire) begin
                done[head] <= 1'b0;  // slot free again
                head       <= head + rename_pkg::rob_idx_t'(1);
            end
            if (dispatch_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + rename_pkg::rob_idx_t'(1);
            end
            // completion last, so one in the dispatch cycle still counts
            if (complete_valid) begin
                done[complete_idx] <= 1'b1;
            end
            count <= count + rename_pkg::rob_cnt_t'(dispatch_valid)
                           - rename_pkg::rob_cnt_t'(retire);
        end
    end

    // entry payload
    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            entries[tail] <= new_entry;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // commit output
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;
        end
    end

    always_ff @(posedge clock) begin
        if (retire) begin
            committed <= entries[head]; // carries the index tagged at rename
        end
    end

endmodule

/* hdl/rename_core.sv */
// top of the rename and retire core, connects queue, rename stage and reorder buffer
module rename_core (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  rename_pkg::inst_t     in_inst,
    input  logic                  complete_valid,  // entry done at this edge
    input  rename_pkg::rob_idx_t  complete_idx,
    output logic                  iq_full,
    output logic                  dispatch_valid,
    output rename_pkg::renamed_t  dispatched,
    output logic                  commit_valid,
    output rename_pkg::commit_t   committed
);

    ////////////////////////////////////////////////////////////////////////////
    // internal wires
    ////////////////////////////////////////////////////////////////////////////

    rename_pkg::inst_t    iq_head;
    logic                 iq_nonempty;
    logic                 iq_pop;
    logic                 rob_full;
    rename_pkg::rob_idx_t alloc_idx;

    inst_queue inst_queue_i (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_inst  (in_inst),
        .pop      (iq_pop),
        .head     (iq_head),
        .nonempty (iq_nonempty),
        .full     (iq_full)
    );

    rename_stage rename_stage_i (
        .clock (clock), .reset (reset),
        .iq_head (iq_head), .iq_nonempty (iq_nonempty),
        .rob_full (rob_full), .alloc_idx (alloc_idx),
        .commit_valid (commit_valid), .committed (committed),   // frees t_old
        .iq_pop (iq_pop), .dispatch_valid (dispatch_valid), .dispatched (dispatched)
    );

    reorder_buffer reorder_buffer_i (
        .clock (clock), .reset (reset),
        .dispatch_valid (dispatch_valid), .dispatched (dispatched),
        .complete_valid (complete_valid), .complete_idx (complete_idx),
        .rob_full (rob_full), .alloc_idx (alloc_idx),
        .commit_valid (commit_valid), .committed (committed)
    );

endmodule

/* dv/rename_core_assertions.sv */
// protocol assertions for the rename core, bound into every rename_core instance
module rename_core_assertions (
    input logic clock,
    input logic reset,
    input logic in_valid,
    input logic iq_full,
    input logic dispatch_valid,
    input logic commit_valid,
    input logic iq_pop
);

    logic                seen_dispatch; // any dispatch pulse since reset
    rename_pkg::iq_cnt_t held;          // queue occupancy from its own handshakes

    always_ff @(posedge clock) begin
        if (reset) begin
            seen_dispatch <= 1'b0;
        end else if (dispatch_valid) begin
            seen_dispatch <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            held <= '0;
        end else begin
            held <= held + rename_pkg::iq_cnt_t'(in_valid && !iq_full)
                         - rename_pkg::iq_cnt_t'(iq_pop);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // properties
    ////////////////////////////////////////////////////////////////////////////

    // first edge of reset still sees unknown outputs
    no_pulse_in_reset: assert property (@(posedge clock)
        reset && $past(reset) |-> !dispatch_valid && !commit_valid)
        else $error("dispatch or commit pulse while reset is high");

    commit_after_dispatch: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> seen_dispatch)
        else $error("commit pulse with no earlier dispatch");

    no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
        iq_pop |-> held != '0)
        else $error("instruction queue popped while empty");

endmodule

bind rename_core rename_core_assertions rename_core_assertions_i (.*);

/* dv/rename_core_tb.sv */
// table-driven testbench for the rename core, checks every dispatch and commit against a model
module rename_core_tb;

    typedef struct packed {
        logic [4:0] dest;
        logic [4:0] src1;
        logic [4:0] src2;
        logic       has_dest;
        logic       hold;      // completions paused while this row is applied
    } row_t;

    localparam int ROWS  = 40;
    localparam int LIMIT = ROWS * 40 + 200;

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 in_valid;
    rename_pkg::inst_t    in_inst;
    logic                 complete_valid;
    rename_pkg::rob_idx_t complete_idx;
    logic                 iq_full;
    logic                 dispatch_valid;
    rename_pkg::renamed_t dispatched;
    logic                 commit_valid;
    rename_pkg::commit_t  committed;

    row_t                  rows [ROWS];
    rename_pkg::phys_reg_t model_map [rename_pkg::ARCH_REG_COUNT];
    rename_pkg::phys_reg_t model_free [$];
    rename_pkg::inst_t     accepted [$];          // taken by the queue, not yet renamed
    rename_pkg::renamed_t  in_flight [$];         // dispatched, not yet committed
    rename_pkg::rob_idx_t  pending [$];           // waiting for a completion strobe
    rename_pkg::rob_idx_t  next_rob = '0;
    rename_pkg::phys_reg_t last_t;                // t of the latest dispatch
    logic                  hold_completions = 1'b0;
    int errors = 0;
    int checks = 0;
    int n_dispatched = 0;
    int n_dropped = 0;
    int cycles = 0;
    int tests_run = 0;
    int tests_failed = 0;

    rename_core rename_core_i (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout, run still busy after %0d cycles", LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checking helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("%0t: %s", $time, what);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, sampled at the falling edge where outputs are stable
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        rename_pkg::renamed_t exp_r;
        rename_pkg::commit_t  exp_c;
        rename_pkg::inst_t    inst;
        if (!reset && commit_valid) begin  // commit first, frees before later renames
            if (in_flight.size() == 0) begin
                check_true(1'b0, "commit pulse with nothing in flight");
            end else begin
                exp_r = in_flight.pop_front();
                exp_c = '{dest: exp_r.dest, has_dest: exp_r.has_dest, t: exp_r.t,
                          t_old: exp_r.t_old, rob_idx: exp_r.rob_idx};
                check_value("committed", exp_c, committed);
                if (exp_r.has_dest) model_free.push_back(exp_r.t_old);
            end
        end
        if (!reset && dispatch_valid) begin
            if (accepted.size() == 0) begin
                check_true(1'b0, "dispatch pulse for an instruction never accepted");
            end else begin
                inst = accepted.pop_front();
                exp_r = '0;
                exp_r.dest     = inst.dest;
                exp_r.has_dest = inst.has_dest;
                exp_r.p1       = model_map[inst.src1];  // sources before own dest
                exp_r.p2       = model_map[inst.src2];
                exp_r.rob_idx  = next_rob;
                next_rob++;
                if (inst.has_dest) begin
                    exp_r.t     = model_free.pop_front();
                    exp_r.t_old = model_map[inst.dest];
                    model_map[inst.dest] = exp_r.t;
                end
                if (n_dispatched == 0) check_value("dispatched.t", 32, dispatched.t);
                check_value("dispatched.p1", exp_r.p1, dispatched.p1);
                check_value("dispatched.p2", exp_r.p2, dispatched.p2);
                check_value("dispatched.t", exp_r.t, dispatched.t);
                check_value("dispatched.t_old", exp_r.t_old, dispatched.t_old);
                check_value("dispatched.rob_idx", exp_r.rob_idx, dispatched.rob_idx);
                check_value("dispatched.dest", exp_r.dest, dispatched.dest);
                check_value("dispatched.has_dest", exp_r.has_dest, dispatched.has_dest);
                last_t = dispatched.t;
                in_flight.push_back(exp_r);
                pending.push_back(exp_r.rob_idx);
                n_dispatched++;
                check_true(in_flight.size() <= 16, "more than 16 instructions in flight");
            end
        end
    end

    // completion strobes, one per cycle, to a random pending rob entry
    always @(posedge clock) begin
        int k;
        #1;
        if (!reset && !hold_completions && pending.size() > 0) begin
            k = $urandom % pending.size();
            complete_idx   = pending[k];
            complete_valid = 1'b1;
            pending.delete(k);
        end else begin
            complete_valid = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // called and returns 1 unit after a rising edge
    task automatic offer_row(int i, bit ignore_full);
        while (!ignore_full && iq_full) begin
            @(posedge clock);
            #1;
        end
        hold_completions = rows[i].hold;
        in_valid = 1'b1;
        in_inst  = '{has_dest: rows[i].has_dest, dest: rows[i].dest,
                     src1: rows[i].src1, src2: rows[i].src2};
        if (!iq_full) accepted.push_back(in_inst);
        else n_dropped++;
        @(posedge clock);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic apply_rows(int first, int last, bit ignore_full);
        for (int i = first; i <= last; i++) offer_row(i, ignore_full);
    endtask

    task automatic drain;
        hold_completions = 1'b0;
        while (accepted.size() != 0 || in_flight.size() != 0) @(posedge clock);
        repeat (2) @(posedge clock);
        #1;
    endtask

    task automatic end_test(string name, int errors_before);
        tests_run++;
        if (errors != errors_before) tests_failed++;
        $display("test %0d %s: %s", tests_run, name,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int e;
        int seen;
        void'($urandom(88931));
        reset = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        complete_valid = 1'b0;
        complete_idx = '0;
        for (int i = 0; i < rename_pkg::ARCH_REG_COUNT; i++) model_map[i] = i;
        for (int i = 32; i < 48; i++) model_free.push_back(i);
        for (int i = 0; i < ROWS; i++) begin
            rows[i].dest     = (i * 7 + 3) % 32;
            rows[i].src1     = (i * 5 + 1) % 32;
            rows[i].src2     = (i * 11) % 32;
            rows[i].has_dest = (i % 5 != 4) && (i != 39);  // every fifth has no dest
            rows[i].hold     = (i >= 14 && i <= 38);
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        e = errors;
        check_value("iq_full", 0, iq_full);
        check_value("dispatch_valid", 0, dispatch_valid);
        check_value("commit_valid", 0, commit_valid);
        apply_rows(0, 1, 0);
        drain();
        end_test("reset and first rename", e);

        e = errors;
        apply_rows(2, 9, 0);
        drain();
        end_test("renamed packets against model", e);

        e = errors;
        apply_rows(10, 13, 0);
        drain();
        end_test("commit order with shuffled completions", e);

        // rob fills, nothing may retire, row 30 waits in the queue
        e = errors;
        apply_rows(14, 30, 0);
        while (in_flight.size() < 16) @(posedge clock);
        seen = n_dispatched;
        repeat (6) @(posedge clock);
        #1;
        check_value("dispatch count while rob full", seen, n_dispatched);
        check_value("in flight count", 16, in_flight.size());
        end_test("rob full holds dispatch", e);

        // row 30 already held, so the last row here finds the queue full
        e = errors;
        apply_rows(31, 38, 1);
        check_value("iq_full", 1, iq_full);
        check_value("dropped count", 1, n_dropped);
        drain();
        check_value("dispatch count", 38, n_dispatched);  // rows 0 to 38 less the dropped one
        end_test("queue full drops input", e);

        // a row with a dest right after shows whether the free list moved
        e = errors;
        seen = model_free[0];
        apply_rows(39, 39, 0);
        offer_row(0, 0);
        drain();
        check_value("dispatched.t", seen, last_t);
        end_test("no destination takes no register", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* rename_core.f */
hdl/rename_pkg.sv
hdl/inst_queue.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/rename_stage.sv
hdl/reorder_buffer.sv
hdl/rename_core.sv
dv/rename_core_assertions.sv
dv/rename_core_tb.sv
